// File: common/rv32i_types.sv
package rv32i_types;

    localparam int NUM_WAYS  = 4;
    localparam int WAY_BITS  = $clog2(NUM_WAYS);
    localparam int NUM_SETS  = 16;
    localparam int SET_BITS  = $clog2(NUM_SETS);
    localparam int LINE_BITS = 256;
    localparam int OFF_BITS  = $clog2(LINE_BITS / 8);
    localparam int TAG_BITS  = 32 - SET_BITS - OFF_BITS;   // Address bits 31 to 9

    // Request held between the two pipeline stages
    typedef struct packed {
        logic [31:0]         addr;
        logic [TAG_BITS-1:0] tag;
        logic [SET_BITS-1:0] set_no;
        logic [OFF_BITS-1:0] offset;
        logic [3:0]          rmask;
        logic [3:0]          wmask;
        logic [31:0]         wdata;
    } stage_reg_t;

    typedef enum logic [1:0] {
        S_COMPARE,
        S_WRITEBACK,
        S_ALLOCATE,
        S_REFILL      // Filled line is re-read
    } cache_state_t;

    // Tree PLRU decode: bit0 picks the half, bit1 ways 0/1, bit2 ways 2/3
    function automatic logic [WAY_BITS-1:0] plru_victim(input logic [2:0] lru);
        if (lru[0]) begin
            return lru[1] ? WAY_BITS'(0) : WAY_BITS'(1);
        end
        return lru[2] ? WAY_BITS'(2) : WAY_BITS'(3);
    endfunction

endpackage : rv32i_types

// File: dcache/cache_way.sv
`timescale 1ns/1ps

module cache_way
import rv32i_types::*;
(
    input   logic                       clk,
    input   logic                       rst,
    input   logic   [SET_BITS-1:0]      rd_set,
    input   logic   [SET_BITS-1:0]      wr_set,
    input   logic                       web,
    input   logic   [LINE_BITS/8-1:0]   wmask,
    input   logic   [LINE_BITS-1:0]     data_in,
    input   logic   [TAG_BITS:0]        tag_in,
    input   logic                       valid_in,
    output  logic   [LINE_BITS-1:0]     data_out,
    output  logic   [TAG_BITS:0]        tag_out,
    output  logic                       valid_out
);

    logic   [LINE_BITS-1:0] data_mem [NUM_SETS];
    logic   [TAG_BITS:0]    tag_mem [NUM_SETS];   // Dirty bit on top
    logic   [NUM_SETS-1:0]  valid_mem;

    always_ff @(posedge clk) begin
        if (!web) begin
            for (int b = 0; b < LINE_BITS/8; b++) begin
                if (wmask[b]) begin
                    data_mem[wr_set][8*b +: 8] <= data_in[8*b +: 8];
                end
            end
            tag_mem[wr_set] <= tag_in;
        end
        data_out <= data_mem[rd_set];   // Old contents on a same-set write
        tag_out  <= tag_mem[rd_set];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_mem <= '0;
            valid_out <= 1'b0;
        end else begin
            if (!web) begin
                valid_mem[wr_set] <= valid_in;
            end
            valid_out <= valid_mem[rd_set];
        end
    end

endmodule : cache_way

// File: dcache/plru_tree.sv
`timescale 1ns/1ps

module plru_tree
import rv32i_types::*;
(
    input   logic                   clk,
    input   logic                   rst,
    input   logic   [SET_BITS-1:0]  rd_set,
    input   logic                   update,
    input   logic   [SET_BITS-1:0]  upd_set,
    input   logic   [WAY_BITS-1:0]  upd_way,
    output  logic   [2:0]           lru_read
);

    // bit0 set: victim in ways 0/1, bit1 set: way 0, bit2 set: way 2
    logic   [2:0]   lru_mem [NUM_SETS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                lru_mem[s] <= '0;
            end
        end else if (update) begin
            lru_mem[upd_set][0] <= upd_way[1];   // Point at the other half
            if (upd_way[1]) begin
                lru_mem[upd_set][2] <= upd_way[0];
            end else begin
                lru_mem[upd_set][1] <= upd_way[0];
            end
        end
    end

    assign lru_read = lru_mem[rd_set];

endmodule : plru_tree

// File: dcache/dcache_stage1.sv
`timescale 1ns/1ps

module dcache_stage1
import rv32i_types::*;
(
    input   logic                       rst,
    input   logic   [31:0]              ufp_addr,
    input   logic   [3:0]               ufp_rmask,
    input   logic   [3:0]               ufp_wmask,
    input   logic   [31:0]              ufp_wdata,

    input   logic                       dfp_write,
    input   logic   [LINE_BITS-1:0]     dfp_rdata,
    input   logic                       dfp_resp,

    input   logic                       read_halt,
    input   logic   [2:0]               lru_read,
    output  logic                       web [NUM_WAYS],
    output  logic   [LINE_BITS-1:0]     data_in [NUM_WAYS],
    output  logic   [TAG_BITS:0]        tag_in [NUM_WAYS],
    output  logic                       valid_in [NUM_WAYS],

    input   stage_reg_t                 stage_reg,
    output  stage_reg_t                 stage_reg_next,

    input   logic   [WAY_BITS-1:0]      write_way,
    output  logic                       write_done,
    input   logic                       write_done_reg,
    input   logic                       write_halt,
    output  logic   [LINE_BITS/8-1:0]   data_array_wmask,
    input   logic                       dirty_halt,
    output  logic                       dfp_switch,
    input   logic                       dfp_write_read
);

    logic   [WAY_BITS-1:0]  victim_way;
    logic   [OFF_BITS-3:0]  word;
    logic   [NUM_WAYS-1:0]  web_low;
    logic                   read_answered;

    assign victim_way    = plru_victim(lru_read);
    assign word          = stage_reg.offset[OFF_BITS-1:2];
    assign read_answered = (stage_reg.rmask != '0) && (stage_reg.wmask == '0);

    // Write-back data accepted, memory now turns to the line fetch
    assign dfp_switch = dfp_resp && dfp_write && dfp_write_read;

    // Array write ports
    always_comb begin
        write_done       = 1'b0;
        data_array_wmask = '1;

        for (int i = 0; i < NUM_WAYS; i++) begin
            web[i]      = 1'b1;
            data_in[i]  = '0;
            tag_in[i]   = '0;
            valid_in[i] = 1'b0;
        end

        if (write_halt) begin
            web[write_way]                    = 1'b0;
            data_in[write_way][32*word +: 32] = stage_reg.wdata;
            tag_in[write_way]                 = {1'b1, stage_reg.tag};   // Line becomes dirty
            valid_in[write_way]               = 1'b1;
            data_array_wmask                  = '0;
            data_array_wmask[4*word +: 4]     = stage_reg.wmask;
            write_done                        = 1'b1;
        end else if (read_halt && dfp_resp && !dirty_halt) begin
            web[victim_way]      = 1'b0;
            data_in[victim_way]  = dfp_rdata;
            tag_in[victim_way]   = {1'b0, stage_reg.tag};   // Clean fill
            valid_in[victim_way] = 1'b1;
        end
    end

    // Request capture
    always_comb begin
        stage_reg_next = stage_reg;

        if (!read_halt) begin
            if (write_halt || write_done_reg || read_answered) begin
                stage_reg_next.rmask = '0;   // Bubble, requester still shows the old request
                stage_reg_next.wmask = '0;
            end else if (stage_reg.wmask == '0) begin
                stage_reg_next.addr   = ufp_addr;
                stage_reg_next.tag    = ufp_addr[31 -: TAG_BITS];
                stage_reg_next.set_no = ufp_addr[OFF_BITS +: SET_BITS];
                stage_reg_next.offset = ufp_addr[OFF_BITS-1:0];
                stage_reg_next.rmask  = ufp_rmask;
                stage_reg_next.wmask  = ufp_wmask;
                stage_reg_next.wdata  = ufp_wdata;
            end
            // A store hit stays in place for its array write
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_WAYS; i++) begin
            web_low[i] = !web[i];
        end
    end

    // Store merge and line fill must never land in two ways at once
    always_comb begin
        if (!rst) begin
            assert ($onehot0(web_low))
                else $error("more than one way write enable active");
        end
    end

endmodule : dcache_stage1

// File: dcache/dcache_stage2.sv
`timescale 1ns/1ps

module dcache_stage2
import rv32i_types::*;
(
    input   logic                   clk,
    input   logic                   rst,
    input   stage_reg_t             stage_reg,
    input   logic   [TAG_BITS:0]    way_tag [NUM_WAYS],
    input   logic                   way_valid [NUM_WAYS],
    input   logic   [LINE_BITS-1:0] way_data [NUM_WAYS],
    input   logic   [2:0]           lru_read,
    input   logic                   dfp_resp,

    output  logic   [31:0]          ufp_rdata,
    output  logic                   ufp_resp,
    output  logic   [31:0]          dfp_addr,
    output  logic                   dfp_read,
    output  logic                   dfp_write,
    output  logic   [LINE_BITS-1:0] dfp_wdata,

    output  logic                   read_halt,
    output  logic                   write_halt,
    output  logic                   dirty_halt,
    output  logic   [WAY_BITS-1:0]  write_way,
    output  logic                   dfp_write_read,
    output  logic                   plru_update,
    output  logic   [WAY_BITS-1:0]  plru_way
);

    cache_state_t           state;
    cache_state_t           state_next;
    logic                   req;
    logic                   hit;
    logic                   miss;
    logic                   victim_dirty;
    logic   [WAY_BITS-1:0]  hit_way;
    logic   [WAY_BITS-1:0]  victim;

    // The store being written this cycle was already answered
    assign req = ((stage_reg.rmask != '0) || (stage_reg.wmask != '0)) && !write_halt;

    assign victim       = plru_victim(lru_read);
    assign victim_dirty = way_valid[victim] && way_tag[victim][TAG_BITS];

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int i = 0; i < NUM_WAYS; i++) begin
            if (way_valid[i] && (way_tag[i][TAG_BITS-1:0] == stage_reg.tag)) begin
                hit     = 1'b1;
                hit_way = WAY_BITS'(i);
            end
        end
    end

    assign miss      = (state == S_COMPARE) && req && !hit;
    assign ufp_resp  = (state == S_COMPARE) && req && hit;
    assign ufp_rdata = way_data[hit_way][32*stage_reg.offset[OFF_BITS-1:2] +: 32];

    assign read_halt  = miss || (state != S_COMPARE);
    assign dirty_halt = (miss && victim_dirty) || (state == S_WRITEBACK);

    assign dfp_write = (state == S_WRITEBACK);
    assign dfp_read  = (state == S_ALLOCATE);
    assign dfp_wdata = way_data[victim];

    always_comb begin
        if (state == S_WRITEBACK) begin
            dfp_addr = {way_tag[victim][TAG_BITS-1:0], stage_reg.set_no, OFF_BITS'(0)};
        end else begin
            dfp_addr = {stage_reg.addr[31:OFF_BITS], OFF_BITS'(0)};
        end
    end

    // Hits and fills both refresh the tree
    assign plru_update = ufp_resp || ((state == S_ALLOCATE) && dfp_resp);
    assign plru_way    = (state == S_ALLOCATE) ? victim : hit_way;

    always_comb begin
        state_next = state;
        unique case (state)
            S_COMPARE: begin
                if (miss) begin
                    state_next = victim_dirty ? S_WRITEBACK : S_ALLOCATE;
                end
            end
            S_WRITEBACK: begin
                if (dfp_resp) begin
                    state_next = S_ALLOCATE;
                end
            end
            S_ALLOCATE: begin
                if (dfp_resp) begin
                    state_next = S_REFILL;
                end
            end
            S_REFILL: state_next = S_COMPARE;
            default:  state_next = S_COMPARE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state          <= S_COMPARE;
            write_halt     <= 1'b0;
            write_way      <= '0;
            dfp_write_read <= 1'b0;
        end else begin
            state      <= state_next;
            write_halt <= ufp_resp && (stage_reg.wmask != '0);   // Array write next cycle
            if (ufp_resp) begin
                write_way <= hit_way;
            end
            if (miss && victim_dirty) begin
                dfp_write_read <= 1'b1;   // This miss evicts a dirty line
            end else if (state == S_REFILL) begin
                dfp_write_read <= 1'b0;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst) !(dfp_read && dfp_write))
        else $error("dfp_read and dfp_write high together");

    assert property (@(posedge clk) disable iff (rst) ufp_resp |-> !(dfp_read || dfp_write))
        else $error("ufp_resp during a memory transaction");

    // Memory side request stays put until answered
    assert property (@(posedge clk) disable iff (rst)
        (dfp_read || dfp_write) && !dfp_resp |=> $stable(dfp_addr) && $stable(dfp_write))
        else $error("dfp request changed before dfp_resp");

endmodule : dcache_stage2

// File: rtl/dcache_top.sv
`timescale 1ns/1ps

module dcache_top
import rv32i_types::*;
(
    input   logic                   clk,
    input   logic                   rst,

    input   logic   [31:0]          ufp_addr,
    input   logic   [3:0]           ufp_rmask,
    input   logic   [3:0]           ufp_wmask,
    output  logic   [31:0]          ufp_rdata,
    input   logic   [31:0]          ufp_wdata,
    output  logic                   ufp_resp,

    output  logic   [31:0]          dfp_addr,
    output  logic                   dfp_read,
    output  logic                   dfp_write,
    input   logic   [LINE_BITS-1:0] dfp_rdata,
    output  logic   [LINE_BITS-1:0] dfp_wdata,
    input   logic                   dfp_resp
);

    stage_reg_t                 stage_reg;
    stage_reg_t                 stage_reg_next;

    logic                       read_halt;
    logic                       write_halt;
    logic                       dirty_halt;
    logic                       write_done;
    logic                       write_done_reg;
    logic                       dfp_switch;
    logic                       dfp_write_read;
    logic                       plru_update;
    logic   [WAY_BITS-1:0]      write_way;
    logic   [WAY_BITS-1:0]      plru_way;
    logic   [2:0]               lru_read;

    logic                       web [NUM_WAYS];
    logic   [LINE_BITS-1:0]     data_in [NUM_WAYS];
    logic   [TAG_BITS:0]        tag_in [NUM_WAYS];
    logic                       valid_in [NUM_WAYS];
    logic   [LINE_BITS/8-1:0]   data_array_wmask;

    logic   [LINE_BITS-1:0]     way_data [NUM_WAYS];
    logic   [TAG_BITS:0]        way_tag [NUM_WAYS];
    logic                       way_valid [NUM_WAYS];

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_reg      <= '0;
            write_done_reg <= 1'b0;
        end else begin
            stage_reg      <= stage_reg_next;
            write_done_reg <= write_done;
        end
    end

    dcache_stage1 u_stage1 (
        .rst              (rst),
        .ufp_addr         (ufp_addr),
        .ufp_rmask        (ufp_rmask),
        .ufp_wmask        (ufp_wmask),
        .ufp_wdata        (ufp_wdata),
        .dfp_write        (dfp_write),
        .dfp_rdata        (dfp_rdata),
        .dfp_resp         (dfp_resp),
        .read_halt        (read_halt),
        .lru_read         (lru_read),
        .web              (web),
        .data_in          (data_in),
        .tag_in           (tag_in),
        .valid_in         (valid_in),
        .stage_reg        (stage_reg),
        .stage_reg_next   (stage_reg_next),
        .write_way        (write_way),
        .write_done       (write_done),
        .write_done_reg   (write_done_reg),
        .write_halt       (write_halt),
        .data_array_wmask (data_array_wmask),
        .dirty_halt       (dirty_halt),
        .dfp_switch       (dfp_switch),
        .dfp_write_read   (dfp_write_read)
    );

    dcache_stage2 u_stage2 (
        .clk            (clk),
        .rst            (rst),
        .stage_reg      (stage_reg),
        .way_tag        (way_tag),
        .way_valid      (way_valid),
        .way_data       (way_data),
        .lru_read       (lru_read),
        .dfp_resp       (dfp_resp),
        .ufp_rdata      (ufp_rdata),
        .ufp_resp       (ufp_resp),
        .dfp_addr       (dfp_addr),
        .dfp_read       (dfp_read),
        .dfp_write      (dfp_write),
        .dfp_wdata      (dfp_wdata),
        .read_halt      (read_halt),
        .write_halt     (write_halt),
        .dirty_halt     (dirty_halt),
        .write_way      (write_way),
        .dfp_write_read (dfp_write_read),
        .plru_update    (plru_update),
        .plru_way       (plru_way)
    );

    plru_tree u_plru (
        .clk      (clk),
        .rst      (rst),
        .rd_set   (stage_reg.set_no),
        .update   (plru_update),
        .upd_set  (stage_reg.set_no),
        .upd_way  (plru_way),
        .lru_read (lru_read)
    );

    // Reads follow stage_reg_next so the outputs line up with stage_reg
    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        cache_way u_way (
            .clk       (clk),
            .rst       (rst),
            .rd_set    (stage_reg_next.set_no),
            .wr_set    (stage_reg.set_no),
            .web       (web[w]),
            .wmask     (data_array_wmask),
            .data_in   (data_in[w]),
            .tag_in    (tag_in[w]),
            .valid_in  (valid_in[w]),
            .data_out  (way_data[w]),
            .tag_out   (way_tag[w]),
            .valid_out (way_valid[w])
        );
    end

    // A write-back never evicts the line that is being requested
    assert property (@(posedge clk) disable iff (rst)
        dfp_switch |-> dfp_addr[31:OFF_BITS] != stage_reg.addr[31:OFF_BITS])
        else $error("write-back of the requested line");

endmodule : dcache_top

// File: dv/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #50 clk = ~clk;   // 100 ns period

endmodule : tb_clock

// File: dv/mem_model.sv
`timescale 1ns/1ps

module mem_model (
    input   logic           clk,
    input   logic           rst,
    input   logic   [31:0]  addr,
    input   logic           read,
    input   logic           write,
    input   logic   [255:0] wdata,
    output  logic   [255:0] rdata,
    output  logic           resp
);

    logic   [255:0] lines [logic [26:0]];   // Keyed by line address
    integer         seed = 32'h82ff_02bd;
    logic           busy;
    int             count;

    // Power-on contents, a mix of every address bit
    function automatic logic [255:0] init_line(input logic [31:0] line_addr);
        logic [255:0] line;
        logic [31:0]  a;
        for (int w = 0; w < 8; w++) begin
            a = {line_addr[31:5], 5'b0} + 32'(4 * w);
            line[32*w +: 32] = (a * 32'h9e37_79b1) ^ 32'h5bd1_e995;
        end
        return line;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            resp  <= 1'b0;
            busy  <= 1'b0;
            rdata <= '0;
        end else if (resp) begin
            resp <= 1'b0;   // Request still visible this edge
            busy <= 1'b0;
        end else if (busy) begin
            if (count <= 1) begin
                if (write) begin
                    lines[addr[31:5]] = wdata;
                end else if (lines.exists(addr[31:5])) begin
                    rdata <= lines[addr[31:5]];
                end else begin
                    rdata <= init_line(addr);
                end
                resp <= 1'b1;
            end
            count <= count - 1;
        end else if (read || write) begin
            busy  <= 1'b1;
            count <= 1 + ($random(seed) & 7);
        end
    end

endmodule : mem_model

// File: dv/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;

    logic           clk;
    logic           rst;
    logic   [31:0]  ufp_addr;
    logic   [3:0]   ufp_rmask;
    logic   [3:0]   ufp_wmask;
    logic   [31:0]  ufp_wdata;
    logic   [31:0]  ufp_rdata;
    logic           ufp_resp;
    logic   [31:0]  dfp_addr;
    logic           dfp_read;
    logic           dfp_write;
    logic   [255:0] dfp_rdata;
    logic   [255:0] dfp_wdata;
    logic           dfp_resp;

    logic   [31:0]  shadow [logic [31:0]];   // Word address to last written value
    logic   [22:0]  ref_tag [16][4];
    bit             ref_valid [16][4];
    bit             ref_dirty [16][4];
    logic   [2:0]   ref_plru [16];
    logic   [31:0]  rd_q [$];
    logic   [31:0]  wr_addr_q [$];
    logic   [255:0] wr_data_q [$];
    integer         seed = 32'h82ff_02bd;
    int             error_count = 0;
    int             cycle_count = 0;

    tb_clock u_clock (.clk(clk));

    dcache_top i_dut (
        .clk       (clk),
        .rst       (rst),
        .ufp_addr  (ufp_addr),
        .ufp_rmask (ufp_rmask),
        .ufp_wmask (ufp_wmask),
        .ufp_rdata (ufp_rdata),
        .ufp_wdata (ufp_wdata),
        .ufp_resp  (ufp_resp),
        .dfp_addr  (dfp_addr),
        .dfp_read  (dfp_read),
        .dfp_write (dfp_write),
        .dfp_rdata (dfp_rdata),
        .dfp_wdata (dfp_wdata),
        .dfp_resp  (dfp_resp)
    );

    mem_model u_mem (
        .clk   (clk),
        .rst   (rst),
        .addr  (dfp_addr),
        .read  (dfp_read),
        .write (dfp_write),
        .wdata (dfp_wdata),
        .rdata (dfp_rdata),
        .resp  (dfp_resp)
    );

    task automatic report_error(input string name, input logic [255:0] exp, act);
        error_count++;
        $display("** Error at %0t: %s expected %h got %h", $time, name, exp, act);
        $display("ERRORS FOUND");
        $fatal(1, "check failed");
    endtask

    function automatic logic [31:0] shadow_word(input logic [31:0] a);
        logic [31:0] w;
        w = {a[31:2], 2'b0};
        if (shadow.exists(w)) begin
            return shadow[w];
        end
        return (w * 32'h9e37_79b1) ^ 32'h5bd1_e995;
    endfunction

    function automatic logic [255:0] shadow_line(input logic [31:0] a);
        logic [255:0] line;
        for (int w = 0; w < 8; w++) begin
            line[32*w +: 32] = shadow_word({a[31:5], 5'b0} + 32'(4 * w));
        end
        return line;
    endfunction

    function automatic int plru_pick(input logic [2:0] p);
        if (p[0]) begin
            return p[1] ? 0 : 1;
        end
        return p[2] ? 2 : 3;
    endfunction

    // Point the tree nodes on the way's path at the other side
    function automatic logic [2:0] plru_touch(input logic [2:0] p, input int way);
        logic [2:0] n;
        n = p;
        n[0] = (way >= 2);
        if (way >= 2) begin
            n[2] = (way == 3);
        end else begin
            n[1] = (way == 1);
        end
        return n;
    endfunction

    task automatic access(input logic [31:0] addr, input logic [3:0] wmask,
                          input logic [31:0] wdata, output logic [31:0] rdata,
                          output int cycles);
        logic [3:0]   set;
        logic [22:0]  tag;
        logic [31:0]  wb_addr;
        logic [31:0]  merged;
        logic [255:0] wb_data;
        bit           hit;
        bit           wb;
        int           way;
        int           rd_n;
        int           wr_n;
        set  = addr[8:5];
        tag  = addr[31:9];
        hit  = 0;
        wb   = 0;
        way  = 0;
        for (int i = 0; i < 4; i++) begin
            if (ref_valid[set][i] && ref_tag[set][i] == tag) begin
                hit = 1;
                way = i;
            end
        end
        if (!hit) begin
            way     = plru_pick(ref_plru[set]);
            wb      = ref_valid[set][way] && ref_dirty[set][way];
            wb_addr = {ref_tag[set][way], set, 5'b0};
            wb_data = shadow_line(wb_addr);
        end
        rd_n = rd_q.size();
        wr_n = wr_addr_q.size();

        @(posedge clk);
        ufp_addr  <= addr;
        ufp_rmask <= (wmask == '0) ? 4'hf : 4'h0;
        ufp_wmask <= wmask;
        ufp_wdata <= wdata;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!ufp_resp);
        rdata = ufp_rdata;
        @(posedge clk);
        ufp_rmask <= '0;
        ufp_wmask <= '0;

        assert (rd_q.size() - rd_n == (hit ? 0 : 1))
            else report_error("dfp_read count", hit ? 0 : 1, rd_q.size() - rd_n);
        assert (wr_addr_q.size() - wr_n == (wb ? 1 : 0))
            else report_error("dfp_write count", wb ? 1 : 0, wr_addr_q.size() - wr_n);
        if (!hit) begin
            assert (rd_q[$] == {addr[31:5], 5'b0})
                else report_error("dfp_addr read", {addr[31:5], 5'b0}, rd_q[$]);
        end
        if (wb) begin
            assert (wr_addr_q[$] == wb_addr)
                else report_error("dfp_addr write", wb_addr, wr_addr_q[$]);
            assert (wr_data_q[$] == wb_data)
                else report_error("dfp_wdata", wb_data, wr_data_q[$]);
        end
        if (wmask == '0) begin
            assert (rdata == shadow_word(addr))
                else report_error("ufp_rdata", shadow_word(addr), rdata);
        end

        if (!hit) begin
            ref_tag[set][way]   = tag;
            ref_valid[set][way] = 1;
            ref_dirty[set][way] = 0;
        end
        ref_plru[set] = plru_touch(ref_plru[set], way);
        if (wmask != '0) begin
            ref_dirty[set][way] = 1;
            merged = shadow_word(addr);
            for (int b = 0; b < 4; b++) begin
                if (wmask[b]) begin
                    merged[8*b +: 8] = wdata[8*b +: 8];
                end
            end
            shadow[{addr[31:2], 2'b0}] = merged;
        end
    endtask

    task automatic cold_read_miss();
        logic [31:0] d;
        int          c;
        access(32'h0000_1044, 4'h0, '0, d, c);
    endtask

    task automatic repeated_read_hit();
        logic [31:0] d;
        int          c;
        int          n;
        n = rd_q.size();
        access(32'h0000_1058, 4'h0, '0, d, c);
        assert (c == 2) else report_error("ufp_resp latency", 2, c);
        assert (rd_q.size() == n) else report_error("dfp_read count", n, rd_q.size());
    endtask

    task automatic masked_write_merge();
        logic [31:0] old_w;
        logic [31:0] exp;
        logic [31:0] d;
        int          c;
        old_w = shadow_word(32'h0000_1048);
        exp   = {old_w[31:24], 8'hc3, old_w[15:8], 8'h5a};   // Lanes 0 and 2
        access(32'h0000_1048, 4'b0101, 32'h11c3_225a, d, c);
        access(32'h0000_1048, 4'h0, '0, d, c);
        assert (d == exp) else report_error("ufp_rdata merged", exp, d);
    endtask

    task automatic set_eviction();
        logic [31:0] d;
        int          c;
        int          n;
        n = wr_addr_q.size();
        for (int t = 0; t < 5; t++) begin
            access({23'(32 + t), 4'd7, 5'd8}, 4'hf, 32'ha000_0000 + 32'(t), d, c);
        end
        assert (wr_addr_q.size() == n + 1)
            else report_error("dfp_write count", n + 1, wr_addr_q.size());
        access({23'(32), 4'd7, 5'd8}, 4'h0, '0, d, c);
        access({23'(33), 4'd7, 5'd8}, 4'h0, '0, d, c);
    endtask

    task automatic random_traffic();
        logic [31:0] a;
        logic [31:0] d;
        logic [31:0] r;
        logic [3:0]  m;
        int          c;
        for (int i = 0; i < 400; i++) begin
            r = $random(seed);
            a = {23'(64 + (r[2:0] % 6)), 3'b0, r[3], r[6:4], 2'b0};
            m = r[7] ? (r[11:8] | 4'b0001) : 4'h0;
            d = $random(seed);
            access(a, m, d, r, c);
        end
    endtask

    always @(posedge clk) begin
        if (!rst) begin
            assert (!(dfp_read && dfp_write))
                else report_error("dfp_read and dfp_write", 0, 1);
            if (dfp_resp && dfp_read) begin
                rd_q.push_back(dfp_addr);
            end
            if (dfp_resp && dfp_write) begin
                wr_addr_q.push_back(dfp_addr);
                wr_data_q.push_back(dfp_wdata);
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= 20000) begin
            $display("Timeout: no end of tests after %0d cycles", cycle_count);
            $display("ERRORS FOUND");
            $fatal(1, "timeout");
        end
    end

    initial begin
        rst       = 1'b1;
        ufp_addr  = '0;
        ufp_rmask = '0;
        ufp_wmask = '0;
        ufp_wdata = '0;
        for (int s = 0; s < 16; s++) begin
            ref_plru[s] = '0;
            for (int w = 0; w < 4; w++) begin
                ref_tag[s][w]   = '0;
                ref_valid[s][w] = 0;
                ref_dirty[s][w] = 0;
            end
        end
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        cold_read_miss();
        repeated_read_hit();
        masked_write_merge();
        set_eviction();
        random_traffic();

        repeat (4) @(posedge clk);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule : tb_dcache

// File: flist.f
common/rv32i_types.sv
dcache/cache_way.sv
dcache/plru_tree.sv
dcache/dcache_stage1.sv
dcache/dcache_stage2.sv
rtl/dcache_top.sv
dv/tb_clock.sv
dv/mem_model.sv
dv/tb_dcache.sv

// File: run.sh
#!/bin/sh
# Build and run the data cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_dcache -o sim_dcache \
    > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim_dcache > sim.log 2>&1 || echo "Simulation ended with an error status"

grep -q "ERRORS FOUND" sim.log && { echo "FAIL, see sim.log"; exit 1; } || \
    { echo "PASS"; exit 0; }
